/* design/ooo_core_pkg.sv */
package ooo_core_pkg;

  // default tag width, 8 ROB entries
  parameter int rob_tag_w = 3;

  typedef enum logic [2:0] {
    OP_LI  = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_XOR = 3'd3,
    OP_MUL = 3'd4
  } opcode_t;

  // instruction as it arrives at the core
  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
  } instr_t;

  // one write-back lane, only the low tag bits are used
  typedef struct packed {
    logic        valid;
    logic [7:0]  tag;
    logic [31:0] value;
  } cdb_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
    logic [7:0]  tag;
  } commit_t;

  typedef struct packed {
    opcode_t     op;
    logic [7:0]  tag;
    logic [31:0] a;
    logic [31:0] b;
  } alu_req_t;

  typedef struct packed {
    logic [7:0]  tag;
    logic [31:0] a;
    logic [31:0] b;
  } mul_req_t;

endpackage

/* design/operand_queue.sv */
module operand_queue #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       do_push;
  logic       do_pop;

  assign push_ready = (count != 2'd2);
  assign pop_valid  = (count != 2'd0);
  assign pop_data   = mem[rd_ptr];
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (do_push) wr_ptr <= ~wr_ptr;
      if (do_pop) rd_ptr <= ~rd_ptr;
      // push and pop together leave the count unchanged
      count <= count + {1'b0, do_push} - {1'b0, do_pop};
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  // one entry held exactly when the pointers differ
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= 2'd2 && ((count == 2'd1) == (wr_ptr != rd_ptr)));

endmodule

/* design/reorder_buffer.sv */
module reorder_buffer #(
  parameter int ROB_IDX_W = ooo_core_pkg::rob_tag_w
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    rob_full,
  input  logic                    rob_push,
  input  logic [4:0]              push_rd,
  output logic [ROB_IDX_W-1:0]    alloc_tag,
  input  ooo_core_pkg::cdb_t      cdb [2],
  input  logic [ROB_IDX_W-1:0]    fwd1_tag,
  input  logic [ROB_IDX_W-1:0]    fwd2_tag,
  output logic                    fwd1_ready,
  output logic [31:0]             fwd1_val,
  output logic                    fwd2_ready,
  output logic [31:0]             fwd2_val,
  output logic                    commit_valid,
  input  logic                    commit_ready,
  output ooo_core_pkg::commit_t   commit_data
);

  localparam int DEPTH = 1 << ROB_IDX_W;

  logic [ROB_IDX_W-1:0] head;
  logic [ROB_IDX_W-1:0] tail;
  // occupied means allocated, ready means result written
  logic                 occupied [DEPTH];
  logic                 ready    [DEPTH];
  logic [4:0]           rd_arr   [DEPTH];
  logic [31:0]          val_arr  [DEPTH];
  logic                 pop;

  // ready flag in bit 32, value below it
  function automatic logic [32:0] fwd_lookup(input logic [ROB_IDX_W-1:0] tag);
    logic [32:0] res;
    res = '0;
    if (occupied[tag]) begin
      if (ready[tag]) res = {1'b1, val_arr[tag]};
      // bypass a result that is on the CDB this cycle
      for (int i = 0; i < 2; i++) begin
        if (cdb[i].valid && cdb[i].tag[ROB_IDX_W-1:0] == tag) begin
          res = {1'b1, cdb[i].value};
        end
      end
    end
    return res;
  endfunction

  assign rob_full     = occupied[head];
  assign alloc_tag    = head;
  assign commit_valid = occupied[tail] && ready[tail];
  assign pop          = commit_valid && commit_ready;

  always_comb begin
    commit_data.rd    = rd_arr[tail];
    commit_data.value = val_arr[tail];
    commit_data.tag   = 8'(tail);
  end

  always_comb begin
    {fwd1_ready, fwd1_val} = fwd_lookup(fwd1_tag);
    {fwd2_ready, fwd2_val} = fwd_lookup(fwd2_tag);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        occupied[i] <= 1'b0;
        ready[i]    <= 1'b0;
      end
    end else begin
      if (pop) begin
        occupied[tail] <= 1'b0;
        ready[tail]    <= 1'b0;
        tail           <= tail + 1'b1;
      end
      for (int i = 0; i < 2; i++) begin
        if (cdb[i].valid) ready[cdb[i].tag[ROB_IDX_W-1:0]] <= 1'b1;
      end
      if (rob_push) begin
        occupied[head] <= 1'b1;
        ready[head]    <= 1'b0;
        head           <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (cdb[i].valid) val_arr[cdb[i].tag[ROB_IDX_W-1:0]] <= cdb[i].value;
    end
    if (rob_push) rd_arr[head] <= push_rd;
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst) rob_push |-> !rob_full);

  for (genvar g = 0; g < 2; g++) begin : g_cdb_chk
    a_cdb_occupied: assert property (@(posedge clk) disable iff (rst)
      cdb[g].valid |-> occupied[cdb[g].tag[ROB_IDX_W-1:0]]);
  end

endmodule

/* design/rename_regfile.sv */
module rename_regfile #(
  parameter int ROB_IDX_W = ooo_core_pkg::rob_tag_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [4:0]            rs1_idx,
  input  logic [4:0]            rs2_idx,
  output logic [31:0]           rs1_val,
  output logic [31:0]           rs2_val,
  output logic                  rs1_pend,
  output logic                  rs2_pend,
  output logic [ROB_IDX_W-1:0]  rs1_tag,
  output logic [ROB_IDX_W-1:0]  rs2_tag,
  input  logic                  rename_we,
  input  logic [4:0]            rename_rd,
  input  logic [ROB_IDX_W-1:0]  rename_tag,
  input  logic                  commit_we,
  input  ooo_core_pkg::commit_t commit_data
);

  logic [31:0]          regs [32];
  logic                 pend [32];
  logic [ROB_IDX_W-1:0] tags [32];
  logic                 clear_pend;

  assign rs1_val  = regs[rs1_idx];
  assign rs2_val  = regs[rs2_idx];
  assign rs1_pend = pend[rs1_idx];
  assign rs2_pend = pend[rs2_idx];
  assign rs1_tag  = tags[rs1_idx];
  assign rs2_tag  = tags[rs2_idx];

  // only the newest producer may clear its register, a fresh rename wins
  assign clear_pend = commit_we && pend[commit_data.rd] &&
                      (tags[commit_data.rd] == commit_data.tag[ROB_IDX_W-1:0]) &&
                      !(rename_we && rename_rd == commit_data.rd);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        pend[i] <= 1'b0;
        tags[i] <= '0;
      end
    end else begin
      // x0 is never written or renamed
      if (commit_we && commit_data.rd != 5'd0) regs[commit_data.rd] <= commit_data.value;
      if (clear_pend) pend[commit_data.rd] <= 1'b0;
      if (rename_we && rename_rd != 5'd0) begin
        pend[rename_rd] <= 1'b1;
        tags[rename_rd] <= rename_tag;
      end
    end
  end

endmodule

/* design/dispatch_unit.sv */
module dispatch_unit #(
  parameter int ROB_IDX_W = ooo_core_pkg::rob_tag_w
) (
  input  logic                   in_valid,
  output logic                   in_ready,
  input  ooo_core_pkg::instr_t   in_instr,
  output logic [4:0]             rs1_idx,
  output logic [4:0]             rs2_idx,
  input  logic [31:0]            rs1_val,
  input  logic [31:0]            rs2_val,
  input  logic                   rs1_pend,
  input  logic                   rs2_pend,
  input  logic [ROB_IDX_W-1:0]   rs1_tag,
  input  logic [ROB_IDX_W-1:0]   rs2_tag,
  output logic [ROB_IDX_W-1:0]   fwd1_tag,
  output logic [ROB_IDX_W-1:0]   fwd2_tag,
  input  logic                   fwd1_ready,
  input  logic [31:0]            fwd1_val,
  input  logic                   fwd2_ready,
  input  logic [31:0]            fwd2_val,
  input  logic                   rob_full,
  input  logic [ROB_IDX_W-1:0]   alloc_tag,
  output logic                   rob_push,
  output logic [4:0]             push_rd,
  output logic                   rename_we,
  output logic [4:0]             rename_rd,
  output logic                   alu_valid,
  input  logic                   alu_ready,
  output ooo_core_pkg::alu_req_t alu_req,
  output logic                   mul_valid,
  input  logic                   mul_ready,
  output ooo_core_pkg::mul_req_t mul_req
);

  import ooo_core_pkg::*;

  logic        is_mul;
  logic        needs_src;
  logic        src1_ok;
  logic        src2_ok;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        lane_ready;

  assign rs1_idx  = in_instr.rs1;
  assign rs2_idx  = in_instr.rs2;
  assign fwd1_tag = rs1_tag;
  assign fwd2_tag = rs2_tag;

  assign is_mul    = (in_instr.op == OP_MUL);
  // LI carries its value in imm and reads no register
  assign needs_src = (in_instr.op != OP_LI);
  assign src1_ok   = !needs_src || !rs1_pend || fwd1_ready;
  assign src2_ok   = !needs_src || !rs2_pend || fwd2_ready;
  assign op_a      = rs1_pend ? fwd1_val : rs1_val;
  assign op_b      = !needs_src ? in_instr.imm : (rs2_pend ? fwd2_val : rs2_val);

  assign lane_ready = is_mul ? mul_ready : alu_ready;
  assign in_ready   = !rob_full && src1_ok && src2_ok && lane_ready;

  assign rob_push  = in_valid && in_ready;
  assign push_rd   = in_instr.rd;
  assign rename_we = rob_push && (in_instr.rd != 5'd0);
  assign rename_rd = in_instr.rd;

  assign alu_valid = rob_push && !is_mul;
  assign mul_valid = rob_push && is_mul;
  assign alu_req   = '{op: in_instr.op, tag: 8'(alloc_tag), a: op_a, b: op_b};
  assign mul_req   = '{tag: 8'(alloc_tag), a: op_a, b: op_b};

endmodule

/* design/alu_unit.sv */
module alu_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  ooo_core_pkg::alu_req_t req,
  output ooo_core_pkg::cdb_t     cdb
);

  import ooo_core_pkg::*;

  logic [31:0] result;

  always_comb begin
    case (req.op)
      OP_ADD:  result = req.a + req.b;
      OP_SUB:  result = req.a - req.b;
      OP_XOR:  result = req.a ^ req.b;
      // LI passes the immediate through on b
      default: result = req.b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) cdb.valid <= 1'b0;
    else cdb.valid <= req_valid;
    cdb.tag   <= req.tag;
    cdb.value <= result;
  end

endmodule

/* design/mul_unit.sv */
module mul_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  ooo_core_pkg::mul_req_t req,
  output ooo_core_pkg::cdb_t     cdb
);

  // stage 1 holds the 16x16 partial products
  logic        s1_valid;
  logic [7:0]  s1_tag;
  logic [31:0] s1_ll;
  logic [15:0] s1_hl;
  logic [15:0] s1_lh;
  // stage 2 has the cross terms folded together
  logic        s2_valid;
  logic [7:0]  s2_tag;
  logic [31:0] s2_ll;
  logic [15:0] s2_cross;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      cdb.valid <= 1'b0;
    end else begin
      s1_valid  <= req_valid;
      s2_valid  <= s1_valid;
      cdb.valid <= s2_valid;
    end
    cdb.tag   <= s2_tag;
    cdb.value <= s2_ll + {s2_cross, 16'h0000};
  end

  always_ff @(posedge clk) begin
    s1_tag   <= req.tag;
    s1_ll    <= req.a[15:0] * req.b[15:0];
    // high x high only reaches bit 32 and above, so it is dropped
    s1_hl    <= 16'(req.a[31:16] * req.b[15:0]);
    s1_lh    <= 16'(req.a[15:0] * req.b[31:16]);
    s2_tag   <= s1_tag;
    s2_ll    <= s1_ll;
    s2_cross <= s1_hl + s1_lh;
  end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> ##3 (cdb.valid && cdb.tag == $past(req.tag, 3) &&
                       cdb.value == $past(req.a, 3) * $past(req.b, 3)));

endmodule

/* design/ooo_core_top.sv */
module ooo_core_top #(
  parameter int ROB_IDX_W = ooo_core_pkg::rob_tag_w
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  ooo_core_pkg::instr_t  in_instr,
  output logic                  commit_valid,
  input  logic                  commit_ready,
  output ooo_core_pkg::commit_t commit_data
);

  import ooo_core_pkg::*;

  logic [4:0]           rs1_idx;
  logic [4:0]           rs2_idx;
  logic [31:0]          rs1_val;
  logic [31:0]          rs2_val;
  logic                 rs1_pend;
  logic                 rs2_pend;
  logic [ROB_IDX_W-1:0] rs1_tag;
  logic [ROB_IDX_W-1:0] rs2_tag;
  logic [ROB_IDX_W-1:0] fwd1_tag;
  logic [ROB_IDX_W-1:0] fwd2_tag;
  logic                 fwd1_ready;
  logic                 fwd2_ready;
  logic [31:0]          fwd1_val;
  logic [31:0]          fwd2_val;
  logic                 rob_full;
  logic [ROB_IDX_W-1:0] alloc_tag;
  logic                 rob_push;
  logic [4:0]           push_rd;
  logic                 rename_we;
  logic [4:0]           rename_rd;
  logic                 alu_push_valid;
  logic                 alu_push_ready;
  alu_req_t             alu_push_req;
  logic                 mul_push_valid;
  logic                 mul_push_ready;
  mul_req_t             mul_push_req;
  logic                 alu_q_valid;
  alu_req_t             alu_q_req;
  logic                 mul_q_valid;
  mul_req_t             mul_q_req;
  cdb_t                 cdb [2];
  logic                 commit_fire;

  // the pop handshake also writes the register file
  assign commit_fire = commit_valid && commit_ready;

  dispatch_unit #(.ROB_IDX_W(ROB_IDX_W)) i_dispatch (
    .in_valid, .in_ready, .in_instr,
    .rs1_idx, .rs2_idx, .rs1_val, .rs2_val,
    .rs1_pend, .rs2_pend, .rs1_tag, .rs2_tag,
    .fwd1_tag, .fwd2_tag, .fwd1_ready, .fwd1_val, .fwd2_ready, .fwd2_val,
    .rob_full, .alloc_tag, .rob_push, .push_rd, .rename_we, .rename_rd,
    .alu_valid(alu_push_valid), .alu_ready(alu_push_ready), .alu_req(alu_push_req),
    .mul_valid(mul_push_valid), .mul_ready(mul_push_ready), .mul_req(mul_push_req)
  );

  rename_regfile #(.ROB_IDX_W(ROB_IDX_W)) i_regfile (
    .clk, .rst, .rs1_idx, .rs2_idx, .rs1_val, .rs2_val,
    .rs1_pend, .rs2_pend, .rs1_tag, .rs2_tag,
    .rename_we, .rename_rd, .rename_tag(alloc_tag),
    .commit_we(commit_fire), .commit_data
  );

  reorder_buffer #(.ROB_IDX_W(ROB_IDX_W)) i_rob (
    .clk, .rst, .rob_full, .rob_push, .push_rd, .alloc_tag, .cdb,
    .fwd1_tag, .fwd2_tag, .fwd1_ready, .fwd1_val, .fwd2_ready, .fwd2_val,
    .commit_valid, .commit_ready, .commit_data
  );

  // both lanes accept every cycle
  operand_queue #(.payload_t(alu_req_t)) i_alu_q (
    .clk, .rst,
    .push_valid(alu_push_valid), .push_ready(alu_push_ready), .push_data(alu_push_req),
    .pop_valid(alu_q_valid), .pop_ready(1'b1), .pop_data(alu_q_req)
  );

  operand_queue #(.payload_t(mul_req_t)) i_mul_q (
    .clk, .rst,
    .push_valid(mul_push_valid), .push_ready(mul_push_ready), .push_data(mul_push_req),
    .pop_valid(mul_q_valid), .pop_ready(1'b1), .pop_data(mul_q_req)
  );

  alu_unit i_alu (.clk, .rst, .req_valid(alu_q_valid), .req(alu_q_req), .cdb(cdb[0]));

  mul_unit i_mul (.clk, .rst, .req_valid(mul_q_valid), .req(mul_q_req), .cdb(cdb[1]));

endmodule

/* sim/ooo_core_tb_util.svh */
`ifndef OOO_CORE_TB_UTIL_SVH
`define OOO_CORE_TB_UTIL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] draw_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

function automatic instr_t make_instr(input opcode_t opc, input int rd, input int rs1,
                                      input int rs2, input logic [31:0] imm);
  return '{op: opc, rd: 5'(rd), rs1: 5'(rs1), rs2: 5'(rs2), imm: imm};
endfunction

function automatic instr_t gen_instr();
  instr_t ins;
  ins.op  = opcode_t'(3'(draw_bits(3) % 5));
  // only x0 to x7, so hazards show up often
  ins.rd  = 5'(draw_bits(3));
  ins.rs1 = 5'(draw_bits(3));
  ins.rs2 = 5'(draw_bits(3));
  ins.imm = draw_bits(32);
  return ins;
endfunction

// applies one instruction to the shadow registers in program order
function automatic commit_t ref_commit(input instr_t ins, input logic [7:0] tag);
  commit_t     c;
  logic [31:0] a;
  logic [31:0] b;
  a = shadow[ins.rs1];
  b = shadow[ins.rs2];
  case (ins.op)
    OP_ADD:  c.value = a + b;
    OP_SUB:  c.value = a - b;
    OP_XOR:  c.value = a ^ b;
    OP_MUL:  c.value = a * b;
    default: c.value = ins.imm;
  endcase
  c.rd  = ins.rd;
  c.tag = tag;
  // x0 stays zero
  if (ins.rd != 5'd0) shadow[ins.rd] = c.value;
  return c;
endfunction

`endif

/* sim/ooo_core_tb.sv */
module ooo_core_tb;

  import ooo_core_pkg::*;

  localparam int TIMEOUT      = 200;
  localparam int RANDOM_COUNT = 300;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  instr_t      in_instr;
  logic        commit_valid;
  logic        commit_ready;
  commit_t     commit_data;
  logic [15:0] lfsr_state;
  logic [31:0] shadow [32];
  commit_t     exp_q [$];
  logic        rand_ready;
  int          tag_seq;
  int          accept_count;
  int          commit_count;
  int          chk_errors;
  int          seq_errors;
  int          test_base;
  int          tests_run;
  int          tests_bad;
  bit          aborted;

  `include "ooo_core_tb_util.svh"

  ooo_core_top #(.ROB_IDX_W(rob_tag_w)) i_dut (
    .clk, .rst, .in_valid, .in_ready, .in_instr,
    .commit_valid, .commit_ready, .commit_data
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // commit checker, compares each handshake with the oldest expected entry
  initial begin
    commit_t want;
    commit_count = 0;
    chk_errors = 0;
    forever begin
      @(negedge clk);
      if (!rst && commit_valid && commit_ready) begin
        commit_count++;
        assert (exp_q.size() > 0) else begin
          $display("commit of tag %0d arrived with no instruction outstanding",
                   commit_data.tag);
          chk_errors++;
        end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          assert (commit_data.rd == want.rd) else begin
            $display("** Error commit_data.rd: expected %h, got %h", want.rd, commit_data.rd);
            chk_errors++;
          end
          assert (commit_data.value == want.value) else begin
            $display("** Error commit_data.value: expected %h, got %h",
                     want.value, commit_data.value);
            chk_errors++;
          end
          assert (commit_data.tag == want.tag) else begin
            $display("** Error commit_data.tag: expected %h, got %h", want.tag, commit_data.tag);
            chk_errors++;
          end
        end
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
    // commit_ready low about a quarter of the cycles
    if (rand_ready) commit_ready = (draw_bits(2) != 32'd0);
  endtask

  // a stalled run stops issuing and ends with the remaining tests empty
  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    seq_errors++;
    aborted = 1'b1;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    commit_ready = 1'b1;
    rand_ready = 1'b0;
    tag_seq = 0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // holds one instruction on the port for up to limit cycles
  task automatic offer(input instr_t ins, input int limit, output bit taken);
    int waited;
    waited = 0;
    taken = 1'b0;
    in_valid = 1'b1;
    in_instr = ins;
    while (!taken && !aborted && waited < limit) begin
      @(negedge clk);
      if (in_ready) begin
        taken = 1'b1;
        exp_q.push_back(ref_commit(ins, 8'(tag_seq % (1 << rob_tag_w))));
        tag_seq++;
        accept_count++;
      end
      next_cycle();
      waited++;
    end
    in_valid = 1'b0;
  endtask

  task automatic send(input instr_t ins);
    bit taken;
    offer(ins, TIMEOUT, taken);
    if (!taken && !aborted) report_timeout("an instruction was never accepted");
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && !aborted && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (exp_q.size() != 0 && !aborted) report_timeout("expected commits did not drain");
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = chk_errors + seq_errors - test_base;
    tests_run++;
    if (errs != 0) tests_bad++;
    $display("test %-14s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    test_base = chk_errors + seq_errors;
  endtask

  initial begin
    bit taken;
    int n_bp;
    int acc0;
    int com0;
    lfsr_state = 16'd85;
    accept_count = 0;
    seq_errors = 0;
    test_base = 0;
    tests_run = 0;
    tests_bad = 0;
    aborted = 1'b0;
    apply_reset();

    for (int r = 1; r < 32; r++) send(make_instr(OP_LI, r, 0, 0, draw_bits(32)));
    send(make_instr(OP_LI, 0, 0, 0, 32'hdead_beef));
    send(make_instr(OP_ADD, 7, 0, 0, '0));
    wait_drain();
    end_test("li_loads");

    // each op reads the result of the one before it
    send(make_instr(OP_LI, 1, 0, 0, 32'h0000_1234));
    send(make_instr(OP_LI, 2, 0, 0, 32'h00f0_0f0f));
    for (int i = 0; i < 12; i++) send(make_instr(opcode_t'(1 + i % 3), 3, 3, 1 + i % 2, '0));
    wait_drain();
    end_test("alu_chain");

    for (int i = 0; i < 4; i++) begin
      send(make_instr(OP_MUL, 4 + i, 1, 2, '0));
      send(make_instr(OP_ADD, 10 + i, 1, 1, '0));
    end
    send(make_instr(OP_MUL, 8, 4, 5, '0));
    wait_drain();
    end_test("mul_then_alu");

    commit_ready = 1'b0;
    n_bp = 0;
    taken = 1'b1;
    while (taken && n_bp < 12) begin
      offer(make_instr(OP_ADD, 20 + n_bp % 4, 1, 2, '0), 8, taken);
      if (taken) n_bp++;
    end
    assert (!taken && n_bp <= 8) else begin
      $display("in_ready stayed high after %0d instructions with commits blocked", n_bp);
      seq_errors++;
    end
    commit_ready = 1'b1;
    wait_drain();
    end_test("back_pressure");

    acc0 = accept_count;
    com0 = commit_count;
    rand_ready = 1'b1;
    for (int i = 0; i < RANDOM_COUNT; i++) send(gen_instr());
    rand_ready = 1'b0;
    commit_ready = 1'b1;
    wait_drain();
    assert (commit_count - com0 == accept_count - acc0) else begin
      $display("random stream committed %0d instructions but accepted %0d",
               commit_count - com0, accept_count - acc0);
      seq_errors++;
    end
    end_test("random_stream");

    // tags restart at zero after a fresh reset
    apply_reset();
    for (int i = 0; i < 12; i++) send(make_instr(OP_LI, 1 + i, 0, 0, 32'(i)));
    wait_drain();
    end_test("tag_sequence");

    $display("%0d tests run, %0d failed, %0d check errors",
             tests_run, tests_bad, chk_errors + seq_errors);
    if (tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* ooo_core.f */
+incdir+sim
design/ooo_core_pkg.sv
design/operand_queue.sv
design/reorder_buffer.sv
design/rename_regfile.sv
design/dispatch_unit.sv
design/alu_unit.sv
design/mul_unit.sv
design/ooo_core_top.sv
sim/ooo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ooo_core_tb -f ooo_core.f \
  -o ooo_core_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ooo_core_sim > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
